/* backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

    localparam int TIMEOUT    = 2000;
    localparam int NUM_RANDOM = 200;
    localparam int XLEN       = cpu_params::XLEN;
    localparam int AREG_BITS  = cpu_params::AREG_BITS;
    localparam int PREG_BITS  = cpu_params::PREG_BITS;

    typedef struct packed {
        logic [AREG_BITS-1:0]   rd;
        logic [XLEN-1:0]        value;
        logic [PREG_BITS-1:0]   pd_old;
    } result_t;

    logic                   clk = 1'b0;
    logic                   rst_i;
    logic                   inst_valid_i;
    uop_types::inst_t       inst_i;
    logic                   inst_ready_o;
    logic                   commit_valid_o;
    uop_types::commit_t     commit_o;

    logic [XLEN-1:0]        model_regs [cpu_params::NUM_AREGS];
    logic [PREG_BITS-1:0]   model_map [cpu_params::NUM_AREGS];
    logic [PREG_BITS-1:0]   free_tags [$];
    result_t                exp_q [$];
    int                     seed;
    int                     commit_count;
    int                     stall_cycles;

    backend_top #(
        .ROB_DEPTH      (16),
        .RS_DEPTH       (4)
    ) uut (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_ready_o   (inst_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            stop_run("a checked value did not match its expected value");
        end
    endtask

    // ****************************************
    // reference model
    // ****************************************
    function automatic result_t ref_exec(input uop_types::inst_t inst);
        result_t            res;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;

        a = model_regs[inst.rs1];
        b = model_regs[inst.rs2];
        case (inst.op)
            uop_types::ADD: res.value = a + b;
            uop_types::SUB: res.value = a - b;
            uop_types::AND: res.value = a & b;
            uop_types::OR:  res.value = a | b;
            uop_types::XOR: res.value = a ^ b;
            uop_types::LI:  res.value = XLEN'($signed(inst.imm));
            default:        res.value = '0;
        endcase
        res.rd = inst.rd;
        // tags leave the free list in the order they were returned to it.
        res.pd_old          = model_map[inst.rd];
        model_map[inst.rd]  = free_tags.pop_front();
        model_regs[inst.rd] = res.value;
        return res;
    endfunction

    function automatic uop_types::inst_t rand_inst();
        uop_types::inst_t   inst;
        logic [31:0]        rnd;
        logic [2:0]         op_sel;

        rnd    = $random(seed);
        op_sel = rnd[2:0];
        // the two unused codes fall back to LI, which keeps fresh constants coming.
        if (op_sel > 3'd5) begin
            op_sel = 3'd5;
        end
        inst.op  = uop_types::alu_op_e'(op_sel);
        inst.rd  = rnd[5:3];
        inst.rs1 = rnd[8:6];
        inst.rs2 = rnd[11:9];
        inst.imm = rnd[27:12];
        return inst;
    endfunction

    // ****************************************
    // stimulus helpers
    // ****************************************
    task automatic send_inst(input uop_types::inst_t inst);
        int     waited;
        logic   accepted;

        waited       = 0;
        accepted     = 1'b0;
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        // ready only moves on a rising edge, so the falling edge shows what the next edge sees.
        while (!accepted) begin
            @(negedge clk);
            accepted = inst_ready_o;
            if (!accepted) begin
                stall_cycles++;
            end
            @(posedge clk);
            waited++;
            if (!accepted && waited >= TIMEOUT) begin
                stop_run("an instruction was not accepted within the timeout");
            end
        end
        exp_q.push_back(ref_exec(inst));
    endtask

    task automatic idle_cycles(input int n);
        inst_valid_i <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_drain();
        int waited;

        waited       = 0;
        inst_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited >= TIMEOUT) begin
                stop_run("outstanding instructions did not commit within the timeout");
            end
        end
    endtask

    always @(negedge clk) begin : commit_check
        result_t exp_res;

        if (!rst_i && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                stop_run("a commit appeared with no instruction outstanding");
            end else begin
                exp_res = exp_q.pop_front();
                check_value("commit_o.rd", XLEN'(commit_o.rd), XLEN'(exp_res.rd));
                check_value("commit_o.value", commit_o.value, exp_res.value);
                check_value("commit_o.pd_old", XLEN'(commit_o.pd_old), XLEN'(exp_res.pd_old));
                free_tags.push_back(exp_res.pd_old);
                commit_count++;
            end
        end
    end

    initial begin : stimulus
        uop_types::inst_t   inst;
        int                 i;
        int                 prev;

        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        seed         = 46;
        commit_count = 0;
        stall_cycles = 0;
        for (i = 0; i < cpu_params::NUM_AREGS; i++) begin
            model_regs[i] = '0;
            model_map[i]  = PREG_BITS'(i);
        end
        for (i = cpu_params::NUM_AREGS; i < cpu_params::NUM_PREGS; i++) begin
            free_tags.push_back(PREG_BITS'(i));
        end

        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        // an idle backend takes input and commits nothing.
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("inst_ready_o", XLEN'(inst_ready_o), XLEN'(1));
            check_value("commit_valid_o", XLEN'(commit_valid_o), XLEN'(0));
        end
        @(posedge clk);

        for (i = 0; i < cpu_params::NUM_AREGS; i++) begin
            inst     = '0;
            inst.op  = uop_types::LI;
            inst.rd  = AREG_BITS'(7 - i);
            inst.imm = 16'(i * 16'h2345 + 16'h0101);
            send_inst(inst);
        end
        idle_cycles(4);
        wait_drain();

        // ****************************************
        // dependent chain
        // ****************************************
        prev = 0;
        for (i = 0; i < 24; i++) begin
            inst     = '0;
            inst.op  = uop_types::alu_op_e'(3'(i % 5));
            inst.rs1 = AREG_BITS'(prev);
            inst.rs2 = AREG_BITS'((prev + 5) % cpu_params::NUM_AREGS);
            // every fourth step overwrites its own source register.
            if (i % 4 != 3) begin
                prev = (prev + 1) % cpu_params::NUM_AREGS;
            end
            inst.rd  = AREG_BITS'(prev);
            send_inst(inst);
        end
        idle_cycles(3);
        wait_drain();

        for (i = 0; i < NUM_RANDOM; i++) begin
            send_inst(rand_inst());
        end
        wait_drain();

        idle_cycles(30);
        if (stall_cycles == 0) begin
            stop_run("inst_ready_o never dropped while instructions were waiting");
        end else begin
            $display("commits checked: %0d, input stall cycles: %0d", commit_count, stall_cycles);
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_top #(
    parameter int ROB_DEPTH = 16,
    parameter int RS_DEPTH  = 4
) (
    input   logic                   clk,
    input   logic                   rst_i,

    input   logic                   inst_valid_i,
    input   uop_types::inst_t       inst_i,
    output  logic                   inst_ready_o,

    output  logic                   commit_valid_o,
    output  uop_types::commit_t     commit_o
);

    logic                               fl_empty;
    logic [cpu_params::PREG_BITS-1:0]   fl_tag;
    logic                               fl_pop;
    logic                               rob_full;
    logic [uop_types::ROB_IDX_BITS-1:0] rob_idx;
    logic                               rob_alloc;
    logic [cpu_params::AREG_BITS-1:0]   rob_rd;
    logic [cpu_params::PREG_BITS-1:0]   rob_pd_old;
    logic                               rs_full;
    logic                               rs_dispatch;
    uop_types::uop_t                    rs_uop;
    logic [cpu_params::PREG_BITS-1:0]   prf_rtag1;
    logic [cpu_params::PREG_BITS-1:0]   prf_rtag2;
    logic                               prf_rdy1;
    logic                               prf_rdy2;
    logic                               prf_clr;
    logic [cpu_params::PREG_BITS-1:0]   rs_rtag1;
    logic [cpu_params::PREG_BITS-1:0]   rs_rtag2;
    logic [cpu_params::XLEN-1:0]        rs_rdata1;
    logic [cpu_params::XLEN-1:0]        rs_rdata2;
    uop_types::cdb_t                    cdb;

    rename_stage rename_stage_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_ready_o   (inst_ready_o),
        .fl_empty_i     (fl_empty),
        .fl_tag_i       (fl_tag),
        .fl_pop_o       (fl_pop),
        .rob_full_i     (rob_full),
        .rob_idx_i      (rob_idx),
        .rob_alloc_o    (rob_alloc),
        .rob_rd_o       (rob_rd),
        .rob_pd_old_o   (rob_pd_old),
        .rs_full_i      (rs_full),
        .rs_dispatch_o  (rs_dispatch),
        .rs_uop_o       (rs_uop),
        .prf_rtag1_o    (prf_rtag1),
        .prf_rtag2_o    (prf_rtag2),
        .prf_rdy1_i     (prf_rdy1),
        .prf_rdy2_i     (prf_rdy2),
        .prf_clr_o      (prf_clr),
        .cdb_i          (cdb)
    );

    // committed entries hand their old mapping back for reuse.
    free_list free_list_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .pop_i          (fl_pop),
        .tag_o          (fl_tag),
        .empty_o        (fl_empty),
        .push_i         (commit_valid_o),
        .push_tag_i     (commit_o.pd_old)
    );

    rob #(
        .ROB_DEPTH      (ROB_DEPTH)
    ) rob_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .alloc_i        (rob_alloc),
        .rd_i           (rob_rd),
        .pd_old_i       (rob_pd_old),
        .idx_o          (rob_idx),
        .full_o         (rob_full),
        .cdb_i          (cdb),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    int_rs #(
        .RS_DEPTH       (RS_DEPTH)
    ) int_rs_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .dispatch_i     (rs_dispatch),
        .uop_i          (rs_uop),
        .full_o         (rs_full),
        .rtag1_o        (rs_rtag1),
        .rtag2_o        (rs_rtag2),
        .rdata1_i       (rs_rdata1),
        .rdata2_i       (rs_rdata2),
        .cdb_i          (cdb),
        .cdb_o          (cdb)
    );

    prf prf_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .rtag1_i        (rs_rtag1),
        .rtag2_i        (rs_rtag2),
        .rdata1_o       (rs_rdata1),
        .rdata2_o       (rs_rdata2),
        .rdy_tag1_i     (prf_rtag1),
        .rdy_tag2_i     (prf_rtag2),
        .rdy1_o         (prf_rdy1),
        .rdy2_o         (prf_rdy2),
        .clr_i          (prf_clr),
        .clr_tag_i      (fl_tag),
        .cdb_i          (cdb)
    );

endmodule

`default_nettype wire

/* cpu_params.sv */
`default_nettype none

// ****************************************
// fixed sizes of the integer backend
// ****************************************
package cpu_params;

    localparam int XLEN      = 32;

    // architectural register file.
    localparam int NUM_AREGS = 8;
    localparam int AREG_BITS = 3;

    // physical register file.
    localparam int NUM_PREGS = 32;
    localparam int PREG_BITS = 5;

endpackage

`default_nettype wire

/* free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input   logic                               clk,
    input   logic                               rst_i,

    input   logic                               pop_i,
    output  logic [cpu_params::PREG_BITS-1:0]   tag_o,
    output  logic                               empty_o,

    input   logic                               push_i,
    input   logic [cpu_params::PREG_BITS-1:0]   push_tag_i
);

    localparam int TAG_BITS  = cpu_params::PREG_BITS;
    localparam int NUM_FREE  = cpu_params::NUM_PREGS - cpu_params::NUM_AREGS;

    logic [TAG_BITS-1:0]    tags_q [cpu_params::NUM_PREGS];
    logic [TAG_BITS-1:0]    head_q;
    logic [TAG_BITS-1:0]    tail_q;
    logic [TAG_BITS:0]      cnt_q;

    assign tag_o   = tags_q[head_q];
    assign empty_o = cnt_q == '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // the first tags are held by the identity map of the alias table.
            for (int i = 0; i < NUM_FREE; i++) begin
                tags_q[i] <= TAG_BITS'(i + cpu_params::NUM_AREGS);
            end
            head_q <= '0;
            tail_q <= TAG_BITS'(NUM_FREE);
            cnt_q  <= (TAG_BITS + 1)'(NUM_FREE);
        end else begin
            if (push_i) begin
                tags_q[tail_q] <= push_tag_i;
                tail_q         <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push_i && !pop_i) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop_i && !push_i) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* int_rs.sv */
`timescale 1ns/1ps
`default_nettype none

module int_rs #(
    parameter int RS_DEPTH = 4
) (
    input   logic                               clk,
    input   logic                               rst_i,

    input   logic                               dispatch_i,
    input   uop_types::uop_t                    uop_i,
    output  logic                               full_o,

    output  logic [cpu_params::PREG_BITS-1:0]   rtag1_o,
    output  logic [cpu_params::PREG_BITS-1:0]   rtag2_o,
    input   logic [cpu_params::XLEN-1:0]        rdata1_i,
    input   logic [cpu_params::XLEN-1:0]        rdata2_i,

    input   uop_types::cdb_t                    cdb_i,
    output  uop_types::cdb_t                    cdb_o
);

    localparam int SEL_BITS = $clog2(RS_DEPTH);
    localparam int CNT_BITS = $clog2(RS_DEPTH + 1);
    localparam int XLEN     = cpu_params::XLEN;

    // entries stay compacted toward index 0, so a lower index is always older.
    uop_types::uop_t        ent_q [RS_DEPTH];
    uop_types::uop_t        woke  [RS_DEPTH + 1];
    uop_types::uop_t        ent_d [RS_DEPTH];
    logic [CNT_BITS-1:0]    cnt_q;
    logic [CNT_BITS-1:0]    wr_idx;
    logic [SEL_BITS-1:0]    sel;
    logic                   issue;
    uop_types::uop_t        iss_uop;
    logic [XLEN-1:0]        alu_res;

    assign full_o = cnt_q == CNT_BITS'(RS_DEPTH);

    always_comb begin
        issue = 1'b0;
        sel   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (i < cnt_q && ent_q[i].ps1_rdy && ent_q[i].ps2_rdy) begin
                issue = 1'b1;
                sel   = SEL_BITS'(i);
            end
        end
    end

    // ****************************************
    // wakeup, compaction and insertion
    // ****************************************
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            woke[i] = ent_q[i];
            if (cdb_i.valid && cdb_i.pd == ent_q[i].ps1) woke[i].ps1_rdy = 1'b1;
            if (cdb_i.valid && cdb_i.pd == ent_q[i].ps2) woke[i].ps2_rdy = 1'b1;
        end
        woke[RS_DEPTH] = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            ent_d[i] = (issue && i >= sel) ? woke[i + 1] : woke[i];
        end
        wr_idx = cnt_q - CNT_BITS'(issue);
        if (dispatch_i) begin
            ent_d[wr_idx[SEL_BITS-1:0]] = uop_i;
        end
    end

    assign iss_uop = ent_q[sel];
    assign rtag1_o = iss_uop.ps1;
    assign rtag2_o = iss_uop.ps2;

    always_comb begin
        case (iss_uop.op)
            uop_types::ADD: alu_res = rdata1_i + rdata2_i;
            uop_types::SUB: alu_res = rdata1_i - rdata2_i;
            uop_types::AND: alu_res = rdata1_i & rdata2_i;
            uop_types::OR:  alu_res = rdata1_i | rdata2_i;
            uop_types::XOR: alu_res = rdata1_i ^ rdata2_i;
            uop_types::LI:  alu_res = {{(XLEN - 16){iss_uop.imm[15]}}, iss_uop.imm};
            default:        alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q       <= '0;
            cdb_o.valid <= 1'b0;
        end else begin
            cnt_q       <= cnt_q + CNT_BITS'(dispatch_i) - CNT_BITS'(issue);
            cdb_o.valid <= issue;
        end
        ent_q         <= ent_d;
        cdb_o.pd      <= iss_uop.pd;
        cdb_o.rob_idx <= iss_uop.rob_idx;
        cdb_o.value   <= alu_res;
    end

endmodule

`default_nettype wire

/* prf.sv */
`timescale 1ns/1ps
`default_nettype none

module prf (
    input   logic                               clk,
    input   logic                               rst_i,

    input   logic [cpu_params::PREG_BITS-1:0]   rtag1_i,
    input   logic [cpu_params::PREG_BITS-1:0]   rtag2_i,
    output  logic [cpu_params::XLEN-1:0]        rdata1_o,
    output  logic [cpu_params::XLEN-1:0]        rdata2_o,

    input   logic [cpu_params::PREG_BITS-1:0]   rdy_tag1_i,
    input   logic [cpu_params::PREG_BITS-1:0]   rdy_tag2_i,
    output  logic                               rdy1_o,
    output  logic                               rdy2_o,

    input   logic                               clr_i,
    input   logic [cpu_params::PREG_BITS-1:0]   clr_tag_i,

    input   uop_types::cdb_t                    cdb_i
);

    logic [cpu_params::XLEN-1:0]    regs_q [cpu_params::NUM_PREGS];
    logic [cpu_params::NUM_PREGS-1:0] rdy_q;

    assign rdata1_o = regs_q[rtag1_i];
    assign rdata2_o = regs_q[rtag2_i];
    assign rdy1_o   = rdy_q[rdy_tag1_i];
    assign rdy2_o   = rdy_q[rdy_tag2_i];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < cpu_params::NUM_PREGS; i++) begin
                regs_q[i] <= '0;
            end
            rdy_q <= '1;
        end else begin
            if (cdb_i.valid) begin
                regs_q[cdb_i.pd] <= cdb_i.value;
                rdy_q[cdb_i.pd]  <= 1'b1;
            end
            // a freshly allocated tag waits for its producer.
            if (clr_i) begin
                rdy_q[clr_tag_i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
    input   logic                               clk,
    input   logic                               rst_i,

    input   logic                               inst_valid_i,
    input   uop_types::inst_t                   inst_i,
    output  logic                               inst_ready_o,

    input   logic                               fl_empty_i,
    input   logic [cpu_params::PREG_BITS-1:0]   fl_tag_i,
    output  logic                               fl_pop_o,

    input   logic                               rob_full_i,
    input   logic [uop_types::ROB_IDX_BITS-1:0] rob_idx_i,
    output  logic                               rob_alloc_o,
    output  logic [cpu_params::AREG_BITS-1:0]   rob_rd_o,
    output  logic [cpu_params::PREG_BITS-1:0]   rob_pd_old_o,

    input   logic                               rs_full_i,
    output  logic                               rs_dispatch_o,
    output  uop_types::uop_t                    rs_uop_o,

    output  logic [cpu_params::PREG_BITS-1:0]   prf_rtag1_o,
    output  logic [cpu_params::PREG_BITS-1:0]   prf_rtag2_o,
    input   logic                               prf_rdy1_i,
    input   logic                               prf_rdy2_i,
    output  logic                               prf_clr_o,

    input   uop_types::cdb_t                    cdb_i
);

    localparam int TAG_BITS = cpu_params::PREG_BITS;

    logic [TAG_BITS-1:0]    rat_q [cpu_params::NUM_AREGS];
    logic [TAG_BITS-1:0]    src1;
    logic [TAG_BITS-1:0]    src2;
    logic [TAG_BITS-1:0]    pd_old;
    logic                   is_li;
    logic                   fire;

    assign inst_ready_o = !fl_empty_i && !rob_full_i && !rs_full_i;
    assign fire         = inst_valid_i && inst_ready_o;

    assign src1   = rat_q[inst_i.rs1];
    assign src2   = rat_q[inst_i.rs2];
    assign pd_old = rat_q[inst_i.rd];
    assign is_li  = inst_i.op == uop_types::LI;

    // every accepted instruction writes rd, so all side effects share one strobe.
    assign fl_pop_o      = fire;
    assign rob_alloc_o   = fire;
    assign rs_dispatch_o = fire;
    assign prf_clr_o     = fire;

    assign rob_rd_o     = inst_i.rd;
    assign rob_pd_old_o = pd_old;
    assign prf_rtag1_o  = src1;
    assign prf_rtag2_o  = src2;

    // a result on the CDB this cycle lands in the PRF on the same edge as dispatch.
    always_comb begin
        rs_uop_o.op      = inst_i.op;
        rs_uop_o.imm     = inst_i.imm;
        rs_uop_o.pd      = fl_tag_i;
        rs_uop_o.ps1     = src1;
        rs_uop_o.ps2     = src2;
        rs_uop_o.ps1_rdy = is_li || prf_rdy1_i || (cdb_i.valid && cdb_i.pd == src1);
        rs_uop_o.ps2_rdy = is_li || prf_rdy2_i || (cdb_i.valid && cdb_i.pd == src2);
        rs_uop_o.rob_idx = rob_idx_i;
        rs_uop_o.pd_old  = pd_old;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < cpu_params::NUM_AREGS; i++) begin
                rat_q[i] <= TAG_BITS'(i);
            end
        end else if (fire) begin
            rat_q[inst_i.rd] <= fl_tag_i;
        end
    end

endmodule

`default_nettype wire

/* rob.sv */
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int ROB_DEPTH = 16
) (
    input   logic                               clk,
    input   logic                               rst_i,

    input   logic                               alloc_i,
    input   logic [cpu_params::AREG_BITS-1:0]   rd_i,
    input   logic [cpu_params::PREG_BITS-1:0]   pd_old_i,
    output  logic [uop_types::ROB_IDX_BITS-1:0] idx_o,
    output  logic                               full_o,

    input   uop_types::cdb_t                    cdb_i,

    output  logic                               commit_valid_o,
    output  uop_types::commit_t                 commit_o
);

    localparam int PTR_BITS = $clog2(ROB_DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;
    localparam int IDX_BITS = uop_types::ROB_IDX_BITS;

    logic [cpu_params::AREG_BITS-1:0]   rd_q     [ROB_DEPTH];
    logic [cpu_params::PREG_BITS-1:0]   pd_old_q [ROB_DEPTH];
    logic [cpu_params::XLEN-1:0]        value_q  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]               done_q;

    logic [PTR_BITS-1:0]                head_q;
    logic [PTR_BITS-1:0]                tail_q;
    logic [CNT_BITS-1:0]                cnt_q;
    logic [PTR_BITS-1:0]                wb_idx;

    assign idx_o  = IDX_BITS'(tail_q);
    assign full_o = cnt_q == CNT_BITS'(ROB_DEPTH);
    assign wb_idx = cdb_i.rob_idx[PTR_BITS-1:0];

    // ****************************************
    // in-order commit from the head
    // ****************************************
    assign commit_valid_o  = cnt_q != '0 && done_q[head_q];
    assign commit_o.rd     = rd_q[head_q];
    assign commit_o.value  = value_q[head_q];
    assign commit_o.pd_old = pd_old_q[head_q];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
            done_q <= '0;
        end else begin
            if (cdb_i.valid) begin
                done_q[wb_idx] <= 1'b1;
            end
            if (alloc_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (commit_valid_o) begin
                head_q <= head_q + 1'b1;
            end
            if (alloc_i && !commit_valid_o) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (commit_valid_o && !alloc_i) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail_q]     <= rd_i;
            pd_old_q[tail_q] <= pd_old_i;
        end
        if (cdb_i.valid) begin
            value_q[wb_idx] <= cdb_i.value;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module backend_tb --timescale 1ns/1ps -Wno-fatal \
    -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vbackend_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

/* uop_types.sv */
`default_nettype none

package uop_types;

    // width of the reorder buffer index carried by micro-ops and the CDB.
    localparam int ROB_IDX_BITS = 4;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        LI  = 3'd5
    } alu_op_e;

    // ****************************************
    // instruction as it arrives at rename
    // ****************************************
    typedef struct packed {
        alu_op_e                            op;
        logic [cpu_params::AREG_BITS-1:0]   rd;
        logic [cpu_params::AREG_BITS-1:0]   rs1;
        logic [cpu_params::AREG_BITS-1:0]   rs2;
        logic [15:0]                        imm;
    } inst_t;

    // renamed micro-op held in the reservation station.
    typedef struct packed {
        alu_op_e                            op;
        logic [15:0]                        imm;
        logic [cpu_params::PREG_BITS-1:0]   pd;
        logic [cpu_params::PREG_BITS-1:0]   ps1;
        logic [cpu_params::PREG_BITS-1:0]   ps2;
        logic                               ps1_rdy;
        logic                               ps2_rdy;
        logic [ROB_IDX_BITS-1:0]            rob_idx;
        logic [cpu_params::PREG_BITS-1:0]   pd_old;
    } uop_t;

    typedef struct packed {
        logic                               valid;
        logic [cpu_params::PREG_BITS-1:0]   pd;
        logic [ROB_IDX_BITS-1:0]            rob_idx;
        logic [cpu_params::XLEN-1:0]        value;
    } cdb_t;

    typedef struct packed {
        logic [cpu_params::AREG_BITS-1:0]   rd;
        logic [cpu_params::XLEN-1:0]        value;
        logic [cpu_params::PREG_BITS-1:0]   pd_old;
    } commit_t;

endpackage

`default_nettype wire

/* verilog.f */
cpu_params.sv
uop_types.sv
rename_stage.sv
free_list.sv
rob.sv
int_rs.sv
prf.sv
backend_top.sv
backend_tb.sv
